// File: source/pdes_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDES configuration package
// Field widths and default sizes of the event engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pdes_cfg_pkg;

   // Logical processes
   localparam int NUM_LP = 8;            // LPs in the model
   localparam int LP_W   = 3;            // Bits of an LP id

   // Event fields
   localparam int TIME_W = 16;           // Bits of a timestamp
   localparam int HIST_W = 4;            // Bits of a history count

   // Engine sizes, overridable per instance through parameters
   localparam int DEF_NUM_CORE    = 4;
   localparam int DEF_QUEUE_DEPTH = 16;
   localparam int DEF_PROC_CYCLES = 4;   // Non-stalled cycles per event

endpackage

// File: source/pdes_msg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDES message package
// Event and result formats, core state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pdes_msg_pkg;

   // Event as it moves between queue, dispatch, cores and outside
   typedef struct packed {
      logic [pdes_cfg_pkg::HIST_W-1:0] hist;       // History count of the LP
      logic [pdes_cfg_pkg::LP_W-1:0]   lp_id;      // Destination LP
      logic [pdes_cfg_pkg::TIME_W-1:0] timestamp;  // Simulation time
   } event_msg_t;

   // Result on the commit stream
   typedef struct packed {
      event_msg_t msg;
      logic [7:0] core;                            // Producing core
   } result_msg_t;

   // Processing core FSM
   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_BUSY,
      CORE_DONE
   } core_state_t;

endpackage

// File: source/event_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event queue
// Bounded slot store that presents its earliest event as head
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module event_queue #(
   parameter int QUEUE_DEPTH = pdes_cfg_pkg::DEF_QUEUE_DEPTH
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     wr_valid,      // Re-enqueue from dispatch
   input  pdes_msg_pkg::event_msg_t wr_msg,
   input  logic                     inject_valid,
   input  pdes_msg_pkg::event_msg_t inject_msg,
   output logic                     inject_ready,
   output pdes_msg_pkg::event_msg_t head,
   output logic                     head_valid,
   input  logic                     head_ready,
   output logic                     empty,
   output logic                     full
);
   import pdes_msg_pkg::*;

   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   event_msg_t             slots    [QUEUE_DEPTH];
   event_msg_t             slot_nxt [QUEUE_DEPTH];   // Contents after this cycle
   logic [QUEUE_DEPTH-1:0] slot_vld;
   logic [QUEUE_DEPTH-1:0] vld_nxt;
   event_msg_t             slot_in;
   logic                   wr_en;
   logic [IDX_W-1:0]       free_idx;
   logic                   spare;                    // At least two free slots
   logic [IDX_W-1:0]       head_idx;
   logic [IDX_W-1:0]       min_idx;
   logic                   min_vld;

   assign full  = &slot_vld;
   assign empty = ~|slot_vld;

   // Lowest free slot, and whether another one is left
   always_comb begin
      logic found;
      found    = 1'b0;
      spare    = 1'b0;
      free_idx = '0;
      for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
         if (!slot_vld[i]) begin
            spare    = spare | found;
            found    = 1'b1;
            free_idx = IDX_W'(i);
         end
      end
   end

   // The last slot stays free for a result that comes back
   assign inject_ready = !wr_valid && spare;
   assign wr_en        = wr_valid || (inject_valid && inject_ready);
   assign slot_in      = wr_valid ? wr_msg : inject_msg;   // Re-enqueue wins

   always_comb begin
      vld_nxt = slot_vld;
      if (head_valid && head_ready)
         vld_nxt[head_idx] = 1'b0;                          // Head leaves
      if (wr_en)
         vld_nxt[free_idx] = 1'b1;
      for (int i = 0; i < QUEUE_DEPTH; i++)
         slot_nxt[i] = (wr_en && free_idx == IDX_W'(i)) ? slot_in : slots[i];
   end

   // Earliest timestamp of the next state, lower slot on a tie
   always_comb begin
      min_idx = '0;
      min_vld = 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (vld_nxt[i] && (!min_vld || slot_nxt[i].timestamp < slot_nxt[min_idx].timestamp)) begin
            min_idx = IDX_W'(i);
            min_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en)
         slots[free_idx] <= slot_in;
      if (!head_valid || head_ready)
         head <= slot_nxt[min_idx];
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         slot_vld   <= '0;
         head_valid <= 1'b0;
         head_idx   <= '0;
      end else begin
         slot_vld <= vld_nxt;
         if (!head_valid || head_ready) begin                // Offered head holds
            head_valid <= min_vld;
            head_idx   <= min_idx;
         end
      end
   end

endmodule

// File: source/event_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event dispatch
// Sends queued events to idle cores and collects their results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module event_dispatch #(
   parameter int NUM_CORE = pdes_cfg_pkg::DEF_NUM_CORE
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  pdes_msg_pkg::event_msg_t                head,
   input  logic                                    head_valid,
   output logic                                    head_ready,
   input  logic                                    full,
   output logic [NUM_CORE-1:0]                     start,
   output pdes_msg_pkg::event_msg_t                start_msg,
   input  logic [NUM_CORE-1:0]                     done,
   input  pdes_msg_pkg::event_msg_t [NUM_CORE-1:0] result,
   output logic [NUM_CORE-1:0]                     done_ack,
   input  logic [pdes_cfg_pkg::TIME_W-1:0]         end_time,
   output logic                                    wr_valid,
   output pdes_msg_pkg::event_msg_t                wr_msg,
   output pdes_msg_pkg::result_msg_t               commit,
   output logic                                    commit_valid,
   input  logic                                    commit_ready,
   output logic                                    sent_msg_vld,
   output logic                                    rcv_msg_vld,
   output pdes_msg_pkg::event_msg_t                mon_msg,
   output logic [$clog2(NUM_CORE)-1:0]             core_id,
   output logic [NUM_CORE-1:0]                     core_active
);
   import pdes_msg_pkg::*;

   localparam int CORE_W = $clog2(NUM_CORE);

   logic [CORE_W-1:0] idle_idx;
   logic [CORE_W-1:0] done_idx;
   logic [CORE_W-1:0] sel_idx;    // Core on the commit stream
   logic [CORE_W-1:0] hold_idx;
   logic              hold_vld;   // Commit offered last cycle and not taken
   event_msg_t        sel_msg;
   logic              collect;
   logic              send;

   function automatic logic [CORE_W-1:0] lowest(input logic [NUM_CORE-1:0] vec);
      logic [CORE_W-1:0] idx;
      idx = '0;
      for (int i = NUM_CORE - 1; i >= 0; i--) begin
         if (vec[i])
            idx = CORE_W'(i);
      end
      return idx;
   endfunction

   assign idle_idx = lowest(~core_active);
   assign done_idx = lowest(done);
   assign sel_idx  = hold_vld ? hold_idx : done_idx;   // Keep commit stable
   assign sel_msg  = result[sel_idx];

   // Collection first, a send only in a cycle without one
   assign commit_valid = (|done) && !full;
   assign collect      = commit_valid && commit_ready;
   assign head_ready   = !(&core_active) && !collect;
   assign send         = head_valid && head_ready;

   assign commit.msg  = sel_msg;
   assign commit.core = 8'(sel_idx);
   assign done_ack    = collect ? (NUM_CORE'(1) << sel_idx) : '0;
   assign wr_valid    = collect && (sel_msg.timestamp < end_time);   // Below horizon
   assign wr_msg      = sel_msg;

   assign sent_msg_vld = send;
   assign rcv_msg_vld  = collect;
   assign mon_msg      = collect ? sel_msg : head;
   assign core_id      = collect ? sel_idx : idle_idx;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         start       <= '0;
         core_active <= '0;
         hold_vld    <= 1'b0;
      end else begin
         start    <= send ? (NUM_CORE'(1) << idle_idx) : '0;
         hold_vld <= commit_valid && !commit_ready;
         if (send)
            core_active[idle_idx] <= 1'b1;
         if (collect)
            core_active[sel_idx] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      hold_idx <= sel_idx;
      if (send)
         start_msg <= head;
   end

endmodule

// File: source/core_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core monitor
// Stalls cores on LP conflicts, tracks history and oldest time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module core_monitor #(
   parameter int NUM_CORE = pdes_cfg_pkg::DEF_NUM_CORE
) (
   input  logic                                             clk,
   input  logic                                             reset,
   input  pdes_msg_pkg::event_msg_t                         msg,
   input  logic                                             sent_msg_vld,
   input  logic                                             rcv_msg_vld,
   input  logic [$clog2(NUM_CORE)-1:0]                      core_id,
   input  logic [NUM_CORE-1:0]                              core_active,
   output logic [NUM_CORE-1:0]                              stall,
   output logic [NUM_CORE-1:0][pdes_cfg_pkg::HIST_W-1:0]    core_hist_cnt,
   output logic [pdes_cfg_pkg::TIME_W-1:0]                  min_time,
   output logic                                             min_time_vld
);
   import pdes_cfg_pkg::*;

   localparam int CORE_W = $clog2(NUM_CORE);
   localparam int LEAVES = 2 ** CORE_W;

   typedef struct packed {
      logic              vld;
      logic [CORE_W-1:0] idx;
      logic [TIME_W-1:0] ts;
   } cand_t;

   logic [TIME_W-1:0]   core_time [NUM_CORE];   // Timestamp per core
   logic [LP_W-1:0]     core_lp   [NUM_CORE];   // LP per core
   logic [HIST_W-1:0]   lp_hist   [NUM_LP];     // Last history per LP
   logic [NUM_CORE-1:0] r_stall;
   logic [NUM_CORE-1:0] c_stall;
   logic [NUM_CORE-1:0] match;                  // Same LP as incoming event
   logic [NUM_CORE-1:0] match_rcv;              // Same LP as returning core
   cand_t               oldest;
   cand_t               earliest;

   // Binary min reduction, heap ordered with the root at node 1
   function automatic cand_t min_tree(input logic [NUM_CORE-1:0] vld,
                                      input logic [TIME_W-1:0] times [NUM_CORE]);
      cand_t node [2*LEAVES];
      cand_t l;
      cand_t r;
      for (int n = 0; n < LEAVES; n++) begin
         node[LEAVES+n] = '0;
         if (n < NUM_CORE)
            node[LEAVES+n] = '{vld[n], CORE_W'(n), times[n]};
      end
      for (int k = LEAVES - 1; k >= 1; k--) begin
         l       = node[2*k];
         r       = node[2*k+1];
         node[k] = (l.vld && (!r.vld || l.ts <= r.ts)) ? l : r;   // Lower core on a tie
      end
      return node[1];
   endfunction

   always_comb begin
      for (int m = 0; m < NUM_CORE; m++) begin
         match[m]     = core_active[m] && core_lp[m] == msg.lp_id && core_id != CORE_W'(m);
         match_rcv[m] = core_active[m] && core_lp[m] == core_lp[core_id]
                        && core_id != CORE_W'(m);
      end
   end

   assign oldest       = min_tree(match_rcv, core_time);   // Waiting core to release
   assign earliest     = min_tree(core_active, core_time);
   assign min_time     = earliest.ts;
   assign min_time_vld = earliest.vld;

   // Current decision joins the registered stall in the same cycle
   always_comb begin
      c_stall = r_stall;
      if (sent_msg_vld && (|match))
         c_stall[core_id] = 1'b1;
      else if (rcv_msg_vld && oldest.vld)
         c_stall[oldest.idx] = 1'b0;
   end

   assign stall = r_stall | c_stall;

   always_ff @(posedge clk) begin
      if (sent_msg_vld) begin
         core_time[core_id] <= msg.timestamp;
         core_lp[core_id]   <= msg.lp_id;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         r_stall       <= '0;
         core_hist_cnt <= '0;
         for (int i = 0; i < NUM_LP; i++)
            lp_hist[i] <= '0;
      end else begin
         r_stall <= c_stall;
         if (sent_msg_vld) begin
            core_hist_cnt[core_id] <= lp_hist[msg.lp_id];
         end else if (rcv_msg_vld) begin
            lp_hist[core_lp[core_id]] <= msg.hist;
            if (oldest.vld)
               core_hist_cnt[oldest.idx] <= msg.hist;   // Released core sees new count
         end
      end
   end

endmodule

// File: source/lp_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LP processing core
// Runs the toy event model with a stall-aware fixed latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module lp_core #(
   parameter int PROC_CYCLES = pdes_cfg_pkg::DEF_PROC_CYCLES
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            start,
   input  pdes_msg_pkg::event_msg_t        start_msg,
   input  logic                            stall,
   input  logic [pdes_cfg_pkg::HIST_W-1:0] hist_cnt,
   output logic                            done,
   output pdes_msg_pkg::event_msg_t        result,
   input  logic                            done_ack
);
   import pdes_cfg_pkg::*;
   import pdes_msg_pkg::*;

   localparam int CNT_W = $clog2(PROC_CYCLES + 1);

   core_state_t      state;
   logic [CNT_W-1:0] lat_cnt;   // Non-stalled busy cycles so far
   event_msg_t       ev;
   logic             finish;

   function automatic event_msg_t apply_model(input event_msg_t e, input logic [HIST_W-1:0] h);
      event_msg_t res;
      res.lp_id     = (e.lp_id == LP_W'(NUM_LP - 1)) ? '0 : e.lp_id + 1'b1;
      res.timestamp = e.timestamp + TIME_W'(e.lp_id) + 1'b1;
      res.hist      = (&h) ? h : h + 1'b1;   // Saturates
      return res;
   endfunction

   assign finish = (state == CORE_BUSY) && !stall && lat_cnt == CNT_W'(PROC_CYCLES - 1);
   assign done   = (state == CORE_DONE);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= CORE_IDLE;
         lat_cnt <= '0;
      end else begin
         case (state)
            CORE_IDLE: if (start) begin
               state   <= CORE_BUSY;
               lat_cnt <= '0;
            end
            CORE_BUSY: if (finish)
               state <= CORE_DONE;
            else if (!stall)
               lat_cnt <= lat_cnt + 1'b1;
            CORE_DONE: if (done_ack)
               state <= CORE_IDLE;
            default: state <= CORE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == CORE_IDLE && start)
         ev <= start_msg;
      if (finish)
         result <= apply_model(ev, hist_cnt);   // Count taken at completion
   end

endmodule

// File: source/pdes_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDES engine top level
// Queue, dispatch, core monitor and the array of LP cores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module pdes_engine #(
   parameter int NUM_CORE    = pdes_cfg_pkg::DEF_NUM_CORE,
   parameter int QUEUE_DEPTH = pdes_cfg_pkg::DEF_QUEUE_DEPTH,
   parameter int PROC_CYCLES = pdes_cfg_pkg::DEF_PROC_CYCLES
) (
   input  logic                            clk,
   input  logic                            reset,
   input  pdes_msg_pkg::event_msg_t        inject,
   input  logic                            inject_valid,
   output logic                            inject_ready,
   output pdes_msg_pkg::result_msg_t       commit,
   output logic                            commit_valid,
   input  logic                            commit_ready,
   input  logic [pdes_cfg_pkg::TIME_W-1:0] end_time,
   output logic [NUM_CORE-1:0]             stall,
   output logic [pdes_cfg_pkg::TIME_W-1:0] active_min_time,
   output logic                            active_min_vld,
   output logic                            idle
);
   import pdes_cfg_pkg::*;
   import pdes_msg_pkg::*;

   event_msg_t                          head;
   logic                                head_valid;
   logic                                head_ready;
   logic                                empty;
   logic                                full;
   logic                                wr_valid;
   event_msg_t                          wr_msg;
   logic [NUM_CORE-1:0]                 start;
   event_msg_t                          start_msg;
   logic [NUM_CORE-1:0]                 done;
   event_msg_t [NUM_CORE-1:0]           result;
   logic [NUM_CORE-1:0]                 done_ack;
   logic                                sent_msg_vld;
   logic                                rcv_msg_vld;
   event_msg_t                          mon_msg;
   logic [$clog2(NUM_CORE)-1:0]         core_id;
   logic [NUM_CORE-1:0]                 core_active;
   logic [NUM_CORE-1:0][HIST_W-1:0]     core_hist_cnt;

   assign idle = empty && !(|core_active);

   event_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
      .clk, .reset, .wr_valid, .wr_msg, .inject_valid,
      .inject_msg(inject), .inject_ready, .head, .head_valid, .head_ready,
      .empty, .full
   );

   event_dispatch #(.NUM_CORE(NUM_CORE)) dispatch_i (
      .clk, .reset, .head, .head_valid, .head_ready, .full, .start, .start_msg,
      .done, .result, .done_ack, .end_time, .wr_valid, .wr_msg, .commit,
      .commit_valid, .commit_ready, .sent_msg_vld, .rcv_msg_vld, .mon_msg,
      .core_id, .core_active
   );

   core_monitor #(.NUM_CORE(NUM_CORE)) monitor_i (
      .clk, .reset, .msg(mon_msg), .sent_msg_vld, .rcv_msg_vld, .core_id,
      .core_active, .stall, .core_hist_cnt, .min_time(active_min_time),
      .min_time_vld(active_min_vld)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : core_gen
      lp_core #(.PROC_CYCLES(PROC_CYCLES)) core_i (
         .clk, .reset, .start(start[g]), .start_msg, .stall(stall[g]),
         .hist_cnt(core_hist_cnt[g]), .done(done[g]), .result(result[g]),
         .done_ack(done_ack[g])
      );
   end

endmodule

// File: test/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock generator
// Free-running clock with a fixed period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module clock_gen #(
   parameter int PERIOD = 20              // In ns
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

endmodule

// File: test/pdes_engine_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDES engine properties
// LP exclusion, monitor handshake and commit hold checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module pdes_engine_props #(
   parameter int NUM_CORE = pdes_cfg_pkg::DEF_NUM_CORE
) (
   input logic                             clk,
   input logic                             reset,
   input logic [NUM_CORE-1:0]              core_active,
   input logic [NUM_CORE-1:0]              stall,
   input logic                             sent_msg_vld,
   input logic                             rcv_msg_vld,
   input logic [$clog2(NUM_CORE)-1:0]      core_id,
   input pdes_msg_pkg::event_msg_t         mon_msg,
   input pdes_msg_pkg::result_msg_t        commit,
   input logic                             commit_valid,
   input logic                             commit_ready
);
   import pdes_cfg_pkg::*;

   logic [LP_W-1:0] lp_of [NUM_CORE];   // LP of the event each core holds
   logic            conflict;
   int              fail_cnt = 0;

   always_ff @(posedge clk) begin
      if (sent_msg_vld)
         lp_of[core_id] <= mon_msg.lp_id;
   end

   always_comb begin
      conflict = 1'b0;
      for (int i = 0; i < NUM_CORE; i++) begin
         for (int j = i + 1; j < NUM_CORE; j++) begin
            if (core_active[i] && core_active[j] && !stall[i] && !stall[j]
                && lp_of[i] == lp_of[j])
               conflict = 1'b1;
         end
      end
   end

   a_lp_exclusive: assert property (@(posedge clk) disable iff (reset) !conflict)
      else begin
         fail_cnt++;
         $error("Two running cores hold the same LP");
      end

   a_one_monitor_op: assert property (@(posedge clk) disable iff (reset)
      !(sent_msg_vld && rcv_msg_vld))
      else begin
         fail_cnt++;
         $error("Send and receive reported to the monitor in one cycle");
      end

   // Offered result holds until the consumer takes it
   a_commit_hold: assert property (@(posedge clk) disable iff (reset)
      commit_valid && !commit_ready |=> commit_valid && $stable(commit))
      else begin
         fail_cnt++;
         $error("Commit changed while stalled by back-pressure");
      end

endmodule

bind pdes_engine pdes_engine_props #(.NUM_CORE(NUM_CORE)) props_i (
   .clk(clk), .reset(reset), .core_active(core_active), .stall(stall),
   .sent_msg_vld(sent_msg_vld), .rcv_msg_vld(rcv_msg_vld), .core_id(core_id),
   .mon_msg(mon_msg), .commit(commit), .commit_valid(commit_valid),
   .commit_ready(commit_ready)
);

// File: test/pdes_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDES engine testbench
// Directed tests against a software event model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
module pdes_engine_tb;
   import pdes_cfg_pkg::*;
   import pdes_msg_pkg::*;

   localparam int NUM_CORE    = DEF_NUM_CORE;
   localparam int NUM_TESTS   = 6;
   localparam int TEST_CYCLES = 4000;
   localparam int HIST_MAX    = (1 << HIST_W) - 1;

   logic                clk;
   logic                reset;
   event_msg_t          inject;
   logic                inject_valid;
   logic                inject_ready;
   result_msg_t         commit;
   logic                commit_valid;
   logic                commit_ready;
   logic [TIME_W-1:0]   end_time;
   logic [NUM_CORE-1:0] stall;
   logic [TIME_W-1:0]   active_min_time;
   logic                active_min_vld;
   logic                idle;

   event_msg_t          expected [$];     // Model results not committed yet
   event_msg_t          pending  [$];     // Events held by the engine
   logic [HIST_W-1:0]   last_hist [NUM_LP];
   logic [NUM_CORE-1:0] stall_seen;
   logic [31:0]         lfsr;
   logic                ordered;          // Commits must follow model order
   logic                rand_ready;
   int                  min_samples;
   int                  err_cnt;

   clock_gen #(.PERIOD(20)) clk_gen_i (.clk(clk));

   pdes_engine #(
      .NUM_CORE(NUM_CORE), .QUEUE_DEPTH(DEF_QUEUE_DEPTH), .PROC_CYCLES(DEF_PROC_CYCLES)
   ) dut_i (
      .clk, .reset, .inject, .inject_valid, .inject_ready, .commit, .commit_valid,
      .commit_ready, .end_time, .stall, .active_min_time, .active_min_vld, .idle
   );

   task automatic fail_run(input string why);
      err_cnt++;
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic compare_result(input string name, input result_msg_t got,
                                 input result_msg_t exp);
      if (got.msg !== exp.msg)
         fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got.msg, exp.msg));
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // Event (lp, t) turns into (lp + 1 mod NUM_LP, t + lp + 1)
   function automatic event_msg_t model_step(input event_msg_t e);
      event_msg_t r;
      r.hist      = '0;
      r.lp_id     = LP_W'((int'(e.lp_id) + 1) % NUM_LP);
      r.timestamp = e.timestamp + TIME_W'(int'(e.lp_id) + 1);
      return r;
   endfunction

   task automatic model_inject(input event_msg_t e);
      event_msg_t work [$];
      event_msg_t r;
      pending.push_back(e);
      work.push_back(e);
      while (work.size() > 0) begin
         r = model_step(work.pop_front());
         expected.push_back(r);
         if (r.timestamp < end_time)          // Goes back into the queue
            work.push_back(r);
      end
   endtask

   task automatic check_commit(input result_msg_t got);
      result_msg_t exp;
      event_msg_t  src;
      int          idx;
      int          h;
      idx = -1;
      foreach (expected[i]) begin
         if (idx < 0 && (ordered || (expected[i].lp_id == got.msg.lp_id
                                     && expected[i].timestamp == got.msg.timestamp)))
            idx = i;
      end
      if (idx < 0)
         fail_run($sformatf("Commit of LP %0d at time %0d matches no outstanding result",
                            got.msg.lp_id, got.msg.timestamp));
      src.hist      = '0;
      src.lp_id     = LP_W'((int'(expected[idx].lp_id) + NUM_LP - 1) % NUM_LP);   // Producing LP
      src.timestamp = expected[idx].timestamp - TIME_W'(int'(src.lp_id) + 1);
      h = int'(last_hist[src.lp_id]) + 1;
      if (h > HIST_MAX)
         h = HIST_MAX;
      exp          = got;
      exp.msg      = expected[idx];
      exp.msg.hist = HIST_W'(h);
      compare_result("commit", got, exp);
      last_hist[src.lp_id] = exp.msg.hist;
      expected.delete(idx);
      idx = -1;
      foreach (pending[i]) begin
         if (idx < 0 && pending[i].lp_id == src.lp_id && pending[i].timestamp == src.timestamp)
            idx = i;
      end
      if (idx >= 0)
         pending.delete(idx);
      if (exp.msg.timestamp < end_time)
         pending.push_back(exp.msg);
   endtask

   task automatic check_min_time();
      logic [TIME_W-1:0] lo;
      if (pending.size() == 0)
         fail_run("active_min_vld is high while no event is in the engine");
      lo = pending[0].timestamp;
      foreach (pending[i]) begin
         if (pending[i].timestamp < lo)
            lo = pending[i].timestamp;
      end
      if (active_min_time < lo)
         fail_run($sformatf("[FAIL] active_min_time: got 0x%0h, expected at least 0x%0h",
                            active_min_time, lo));
      min_samples++;
   endtask

   // Outputs sampled mid-cycle ahead of the transfer on the next rising edge
   always @(negedge clk) begin
      if (!reset) begin
         if (dut_i.props_i.fail_cnt != 0)
            fail_run("A bound assertion on the engine failed");
         stall_seen = stall_seen | stall;
         if (active_min_vld)
            check_min_time();
         if (commit_valid && commit_ready)
            check_commit(commit);
      end
   end

   always @(posedge clk) begin
      if (rand_ready) begin
         #2;
         lfsr         = lfsr_next(lfsr);
         commit_ready = lfsr[0];                // One step per bit
      end
   end

   task automatic reset_dut();
      reset = 1'b1;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      expected.delete();
      pending.delete();
      foreach (last_hist[i])
         last_hist[i] = '0;
      stall_seen  = '0;
      min_samples = 0;
   endtask

   task automatic inject_event(input int lp, input int ts);
      event_msg_t e;
      int         n;
      n           = 0;
      e.hist      = '0;
      e.lp_id     = LP_W'(lp);
      e.timestamp = TIME_W'(ts);
      inject       = e;
      inject_valid = 1'b1;
      @(negedge clk);
      while (!inject_ready) begin
         @(negedge clk);
         n++;
         if (n > TEST_CYCLES)
            fail_run("Timed out waiting for inject_ready");
      end
      model_inject(e);
      @(posedge clk);
      #2;
      inject_valid = 1'b0;
   endtask

   task automatic wait_drained(input string what);
      int n;
      n = 0;
      while (expected.size() > 0 || !idle) begin
         @(negedge clk);
         n++;
         if (n > TEST_CYCLES)
            fail_run($sformatf("Timed out waiting for the %s run to finish", what));
      end
      @(posedge clk);
      #2;
   endtask

   task automatic test_reset_state();
      reset_dut();
      compare_bit("commit_valid", commit_valid, 1'b0);
      compare_bit("stall", |stall, 1'b0);
      compare_bit("active_min_vld", active_min_vld, 1'b0);
      compare_bit("inject_ready", inject_ready, 1'b1);
      compare_bit("idle", idle, 1'b1);
   endtask

   task automatic test_single_chain();
      reset_dut();
      end_time = TIME_W'(60);
      ordered  = 1'b1;
      inject_event(2, 10);
      wait_drained("single chain");
      ordered = 1'b0;
      compare_bit("idle", idle, 1'b1);
   endtask

   task automatic test_history();
      reset_dut();
      end_time = TIME_W'(700);               // About twenty laps over all LPs
      inject_event(0, 0);
      wait_drained("history chain");
   endtask

   task automatic test_same_lp();
      reset_dut();
      end_time = '0;                         // Nothing is re-enqueued
      inject_event(3, 20);
      inject_event(3, 30);
      wait_drained("same LP");
      compare_bit("stall[0] seen", stall_seen[0], 1'b0);
      compare_bit("stall[1] seen", stall_seen[1], 1'b1);
   endtask

   task automatic test_backpressure();
      reset_dut();
      end_time   = TIME_W'(150);
      rand_ready = 1'b1;
      inject_event(0, 5);
      inject_event(1, 7);
      inject_event(4, 3);
      inject_event(6, 9);
      inject_event(2, 12);
      wait_drained("back-pressure");
      rand_ready = 1'b0;
      @(posedge clk);
      #2;
      commit_ready = 1'b1;
   endtask

   task automatic test_min_time();
      reset_dut();
      end_time = TIME_W'(200);
      inject_event(5, 40);
      inject_event(1, 2);
      inject_event(3, 2);
      inject_event(7, 15);
      inject_event(0, 90);
      inject_event(2, 60);
      wait_drained("minimum time");
      compare_bit("active_min_time sampled", min_samples > 0, 1'b1);
      compare_bit("active_min_vld", active_min_vld, 1'b0);
   endtask

   initial begin
      reset        = 1'b1;
      inject       = '0;
      inject_valid = 1'b0;
      commit_ready = 1'b1;
      end_time     = '0;
      ordered      = 1'b0;
      rand_ready   = 1'b0;
      stall_seen   = '0;
      min_samples  = 0;
      err_cnt      = 0;
      lfsr         = 32'd78333;
      test_reset_state();
      test_single_chain();
      test_history();
      test_same_lp();
      test_backpressure();
      test_min_time();
      if (err_cnt == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Run limit covers every test plus its reset
   initial begin
      repeat (NUM_TESTS * (TEST_CYCLES + 10)) @(posedge clk);
      $display("Watchdog expired before the tests completed");
      $display("Verification failed");
      $fatal(1);
   end

endmodule

// File: verilog.f
source/pdes_cfg_pkg.sv
source/pdes_msg_pkg.sv
source/event_queue.sv
source/event_dispatch.sv
source/core_monitor.sv
source/lp_core.sv
source/pdes_engine.sv
test/clock_gen.sv
test/pdes_engine_props.sv
test/pdes_engine_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PDES engine testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
   --top-module pdes_engine_tb -f verilog.f -o pdes_sim

./obj_dir/pdes_sim +verilator+error+limit+10 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation PASSED"
